/* common/fpa_types_pkg.sv */
package fpa_types_pkg;

	// mantissa and bus widths
	parameter int MANT_W = 40;
	parameter int WORD_W = 16;
	parameter int NIB_W = 4;
	parameter int SHCNT_W = 6;

	// normalize gives up one place short of the full mantissa
	parameter int NORM_MAX = MANT_W - 1;

	// bit 0 is the sign and the most significant bit
	typedef logic [0:MANT_W-1] mant_t;

	// host data word, bit 0 most significant
	typedef logic [0:WORD_W-1] word_t;

	// one ALU slice operand
	typedef logic [0:NIB_W-1] nib_t;

	// normalize shift count, plain binary
	typedef logic [SHCNT_W-1:0] shcnt_t;

endpackage

/* common/fpa_ctl_pkg.sv */
package fpa_ctl_pkg;

	// host opcodes
	// normalize is OP_SHL with w bit 0 set
	typedef enum logic [2:0] {
		OP_LD0 = 3'd0,
		OP_LD1 = 3'd1,
		OP_LD2 = 3'd2,
		OP_TC  = 3'd3,
		OP_ADD = 3'd4,
		OP_SUB = 3'd5,
		OP_SHL = 3'd6,
		OP_SHR = 3'd7
	} fpa_op_t;

	// ZP readback source
	typedef enum logic [1:0] {ZP_T0, ZP_T1, ZP_T2, ZP_FLAGS} zp_sel_t;

	// K bus source
	typedef enum logic [1:0] {K_SUM, K_W, K_ZERO} ksrc_t;

	// T update mode
	typedef enum logic [1:0] {T_HOLD, T_SHR, T_SHL, T_LOAD} tmode_t;

	typedef enum logic [1:0] {S_IDLE, S_EXEC, S_NORM, S_DONE} seq_state_t;

	// segment enables in T order (0-15, 16-31, 32-39)
	parameter logic [0:2] SEG_NONE = 3'b000;
	parameter logic [0:2] SEG_T0 = 3'b100;
	parameter logic [0:2] SEG_T1 = 3'b010;
	parameter logic [0:2] SEG_T2 = 3'b001;
	parameter logic [0:2] SEG_ALL = 3'b111;

	// slice select codes for A plus B and A minus B
	parameter logic [3:0] ALU_S_ADD = 4'b1001;
	parameter logic [3:0] ALU_S_SUB = 4'b0110;

endpackage

/* fpa/alu181.sv */
`timescale 1ns/1ps

module alu181 (
	input fpa_types_pkg::nib_t a,
	input fpa_types_pkg::nib_t b,
	input logic cin_n,
	input logic [3:0] s,
	output fpa_types_pkg::nib_t f,
	output logic g_n,
	output logic p_n,
	output logic cout_n
);
	import fpa_types_pkg::*;

	nib_t prop;
	nib_t gen;
	nib_t half;
	logic [0:4] cy;
	logic grp_g;

	// per-bit terms of the arithmetic mode, logic mode not modelled
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			prop[i] = a[i] | (b[i] & s[0]) | (~b[i] & s[1]);
			gen[i] = (a[i] & ~b[i] & s[2]) | (a[i] & b[i] & s[3]);
		end
	end

	// gen implies prop so this is the half sum
	assign half = prop & ~gen;

	// carry enters at bit 3
	always_comb begin
		cy[4] = ~cin_n;
		for (int i = 3; i >= 0; i--) begin
			cy[i] = gen[i] | (prop[i] & cy[i + 1]);
		end
	end

	assign f = half ^ cy[1:4];

	// group generate for the look-ahead unit
	always_comb begin
		grp_g = 1'b0;
		for (int i = 3; i >= 0; i--) begin
			grp_g = gen[i] | (prop[i] & grp_g);
		end
	end

	assign g_n = ~grp_g;
	assign p_n = ~&prop;
	assign cout_n = ~cy[0];

endmodule

/* fpa/carry182.sv */
`timescale 1ns/1ps

module carry182 (
	input logic cin_n,
	input logic [3:0] g_n,
	input logic [3:0] p_n,
	output logic c1_n,
	output logic c2_n,
	output logic c3_n,
	output logic gg_n,
	output logic pg_n
);

	// index 0 is the least significant slice
	logic [3:0] g;
	logic [3:0] p;
	logic c0;

	assign g = ~g_n;
	assign p = ~p_n;
	assign c0 = ~cin_n;

	assign c1_n = ~(g[0] | (p[0] & c0));
	assign c2_n = ~(g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0));
	assign c3_n = ~(g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & c0));

	// group terms chain into the next block up
	assign gg_n = ~(g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]));
	assign pg_n = ~&p;

endmodule

/* fpa/fpa.sv */
`timescale 1ns/1ps

module fpa #(
	parameter int MANT_W = fpa_types_pkg::MANT_W
) (
	input logic cclk,
	input logic rst_n,
	input fpa_types_pkg::word_t w,
	input logic [0:2] seg_en,
	input fpa_ctl_pkg::tmode_t t_mode,
	input fpa_ctl_pkg::ksrc_t k_src,
	input logic alu_sub,
	input logic c_load,
	input logic flag_en,
	input fpa_ctl_pkg::zp_sel_t zp_sel,
	input fpa_types_pkg::shcnt_t norm_cnt,
	output fpa_types_pkg::word_t zp,
	output logic t0_t1,
	output logic t_zero
);
	import fpa_types_pkg::*;
	import fpa_ctl_pkg::*;

	localparam int NSLICE = MANT_W / 4;
	localparam int NBLK = MANT_W / 16;
	// slices under look-ahead, the rest ripple below them
	localparam int NLA = 4 * NBLK;

	mant_t t;
	mant_t t_next;
	mant_t c;
	mant_t k;
	mant_t sum;

	logic [3:0] alu_s;
	logic [0:NSLICE-1] slc_cin_n;
	logic [0:NSLICE-1] slc_g_n;
	logic [0:NSLICE-1] slc_p_n;
	logic [0:NSLICE-1] slc_cout_n;
	logic [0:NBLK] blk_cy_n;
	logic [0:NBLK-1] blk_gg_n;
	logic [0:NBLK-1] blk_pg_n;

	logic z_f;
	logic n_f;
	logic v_f;
	logic c_f;
	logic opnd_sign;

	// K bus
	always_comb begin
		k = '0;
		unique case (k_src)
			K_SUM: k = sum;
			K_W: k = {w, w, w[0:7]};
			K_ZERO: k = '0;
		endcase
	end

	// right shift keeps the sign in bit 0
	always_comb begin
		unique case (t_mode)
			T_HOLD: t_next = t;
			T_SHR: t_next = {t[0], t[0:MANT_W-2]};
			T_SHL: t_next = {t[1:MANT_W-1], 1'b0};
			T_LOAD: t_next = k;
		endcase
	end

	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			t <= '0;
		end else begin
			if (seg_en[0])
				t[0:15] <= t_next[0:15];
			if (seg_en[1])
				t[16:31] <= t_next[16:31];
			if (seg_en[2])
				t[32:MANT_W-1] <= t_next[32:MANT_W-1];
		end
	end

	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n)
			c <= '0;
		else if (c_load)
			c <= t;
	end

	// adder
	assign alu_s = alu_sub ? ALU_S_SUB : ALU_S_ADD;
	// subtract is A minus B minus 1 plus carry
	assign slc_cin_n[NSLICE-1] = ~alu_sub;

	generate
		for (genvar i = 0; i < NSLICE; i++) begin : g_slice
			alu181 alu181_inst (
				.a(t[4*i +: 4]),
				.b(c[4*i +: 4]),
				.cin_n(slc_cin_n[i]),
				.s(alu_s),
				.f(sum[4*i +: 4]),
				.g_n(slc_g_n[i]),
				.p_n(slc_p_n[i]),
				.cout_n(slc_cout_n[i])
			);
		end

		// low byte ripples
		for (genvar i = NLA; i < NSLICE - 1; i++) begin : g_ripple
			assign slc_cin_n[i] = slc_cout_n[i + 1];
		end

		// 16-bit blocks, block 0 holds the sign
		for (genvar b = 0; b < NBLK; b++) begin : g_block
			carry182 carry182_inst (
				.cin_n(blk_cy_n[b + 1]),
				.g_n(slc_g_n[4*b +: 4]),
				.p_n(slc_p_n[4*b +: 4]),
				.c1_n(slc_cin_n[4*b + 2]),
				.c2_n(slc_cin_n[4*b + 1]),
				.c3_n(slc_cin_n[4*b]),
				.gg_n(blk_gg_n[b]),
				.pg_n(blk_pg_n[b])
			);
			assign slc_cin_n[4*b + 3] = blk_cy_n[b + 1];
			assign blk_cy_n[b] = blk_gg_n[b] & (blk_pg_n[b] | blk_cy_n[b + 1]);
		end
	endgenerate

	assign blk_cy_n[NBLK] = slc_cout_n[NLA];

	// sign of the second operand as seen by the adder
	assign opnd_sign = c[0] ^ alu_sub;

	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			z_f <= 1'b0;
			n_f <= 1'b0;
			v_f <= 1'b0;
			c_f <= 1'b0;
		end else if (flag_en) begin
			z_f <= ~|sum;
			n_f <= sum[0];
			v_f <= (t[0] == opnd_sign) && (sum[0] != t[0]);
			c_f <= ~blk_cy_n[0];
		end
	end

	// ZP readback
	always_comb begin
		unique case (zp_sel)
			ZP_T0: zp = t[0:15];
			ZP_T1: zp = t[16:31];
			ZP_T2: zp = {t[32:MANT_W-1], 8'h00};
			ZP_FLAGS: zp = {z_f, n_f, v_f, c_f, 6'b000000, norm_cnt};
		endcase
	end

	assign t0_t1 = t[0] ^ t[1];
	assign t_zero = ~|t;

	// sum written to T while C captures the old T is never issued
	assert property (@(posedge cclk) disable iff (!rst_n)
		!(c_load && |seg_en && t_mode == T_LOAD && k_src == K_SUM));

	assert property (@(posedge cclk) disable iff (!rst_n)
		norm_cnt <= shcnt_t'(NORM_MAX));

	// look-ahead carry out of bit 0 agrees with the top slice
	assert property (@(posedge cclk) disable iff (!rst_n)
		slc_cout_n[0] == blk_cy_n[0]);

endmodule

/* source/fpa_seq.sv */
`timescale 1ns/1ps

module fpa_seq (
	input logic cclk,
	input logic rst_n,
	input logic start,
	input fpa_ctl_pkg::fpa_op_t op,
	input logic norm_req,
	input logic t0_t1,
	input logic t_zero,
	output logic busy,
	output logic done,
	output logic [0:2] seg_en,
	output fpa_ctl_pkg::tmode_t t_mode,
	output fpa_ctl_pkg::ksrc_t k_src,
	output logic alu_sub,
	output logic c_load,
	output logic flag_en,
	output fpa_types_pkg::shcnt_t norm_cnt
);
	import fpa_types_pkg::*;
	import fpa_ctl_pkg::*;

	seq_state_t state;
	seq_state_t state_nx;
	fpa_op_t op_q;
	logic accept;
	logic norm_start;
	logic norm_stop;

	assign busy = (state == S_EXEC) || (state == S_NORM);
	assign done = (state == S_DONE);

	// start can follow done directly
	assign accept = start && !busy;
	assign norm_start = accept && (op == OP_SHL) && norm_req;
	assign norm_stop = t0_t1 || t_zero || (norm_cnt == shcnt_t'(NORM_MAX));

	always_comb begin
		state_nx = state;
		unique case (state)
			S_IDLE, S_DONE: begin
				if (norm_start)
					state_nx = S_NORM;
				else if (accept)
					state_nx = S_EXEC;
				else
					state_nx = S_IDLE;
			end
			S_EXEC: state_nx = S_DONE;
			S_NORM: begin
				if (norm_stop)
					state_nx = S_DONE;
			end
		endcase
	end

	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			op_q <= OP_LD0;
		end else begin
			state <= state_nx;
			if (accept)
				op_q <= op;
		end
	end

	// one count per left shift
	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n)
			norm_cnt <= '0;
		else if (norm_start)
			norm_cnt <= '0;
		else if (state == S_NORM && !norm_stop)
			norm_cnt <= norm_cnt + shcnt_t'(1);
	end

	// datapath strobes
	always_comb begin
		seg_en = SEG_NONE;
		t_mode = T_HOLD;
		k_src = K_ZERO;
		alu_sub = 1'b0;
		c_load = 1'b0;
		flag_en = 1'b0;
		if (state == S_EXEC) begin
			unique case (op_q)
				OP_LD0: begin
					seg_en = SEG_T0;
					t_mode = T_LOAD;
					k_src = K_W;
				end
				OP_LD1: begin
					seg_en = SEG_T1;
					t_mode = T_LOAD;
					k_src = K_W;
				end
				OP_LD2: begin
					seg_en = SEG_T2;
					t_mode = T_LOAD;
					k_src = K_W;
				end
				OP_TC: c_load = 1'b1;
				OP_ADD, OP_SUB: begin
					seg_en = SEG_ALL;
					t_mode = T_LOAD;
					k_src = K_SUM;
					alu_sub = (op_q == OP_SUB);
					flag_en = 1'b1;
				end
				OP_SHL: begin
					seg_en = SEG_ALL;
					t_mode = T_SHL;
				end
				OP_SHR: begin
					seg_en = SEG_ALL;
					t_mode = T_SHR;
				end
			endcase
		end else if (state == S_NORM && !norm_stop) begin
			seg_en = SEG_ALL;
			t_mode = T_SHL;
		end
	end

	assert property (@(posedge cclk) disable iff (!rst_n) done |=> !done);

endmodule

/* source/fpa_top.sv */
`timescale 1ns/1ps

module fpa_top #(
	parameter int MANT_W = fpa_types_pkg::MANT_W
) (
	input logic cclk,
	input logic rst_n,
	input logic start,
	input fpa_ctl_pkg::fpa_op_t op,
	input fpa_types_pkg::word_t w,
	input fpa_ctl_pkg::zp_sel_t zp_sel,
	output fpa_types_pkg::word_t zp,
	output logic busy,
	output logic done
);
	import fpa_types_pkg::*;
	import fpa_ctl_pkg::*;

	logic [0:2] seg_en;
	tmode_t t_mode;
	ksrc_t k_src;
	logic alu_sub;
	logic c_load;
	logic flag_en;
	logic t0_t1;
	logic t_zero;
	shcnt_t norm_cnt;

	// w bit 0 turns OP_SHL into normalize
	fpa_seq fpa_seq_inst (
		.cclk(cclk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.norm_req(w[0]),
		.t0_t1(t0_t1),
		.t_zero(t_zero),
		.busy(busy),
		.done(done),
		.seg_en(seg_en),
		.t_mode(t_mode),
		.k_src(k_src),
		.alu_sub(alu_sub),
		.c_load(c_load),
		.flag_en(flag_en),
		.norm_cnt(norm_cnt)
	);

	fpa #(
		.MANT_W(MANT_W)
	) fpa_inst (
		.cclk(cclk),
		.rst_n(rst_n),
		.w(w),
		.seg_en(seg_en),
		.t_mode(t_mode),
		.k_src(k_src),
		.alu_sub(alu_sub),
		.c_load(c_load),
		.flag_en(flag_en),
		.zp_sel(zp_sel),
		.norm_cnt(norm_cnt),
		.zp(zp),
		.t0_t1(t0_t1),
		.t_zero(t_zero)
	);

endmodule

/* testbench/fpa_tb.sv */
`timescale 1ns/1ps

module fpa_tb;
	import fpa_types_pkg::*;
	import fpa_ctl_pkg::*;

	localparam int N_OPS = 400;
	localparam int DONE_TIMEOUT = 100;
	// normalize stops after this many shifts
	localparam int MAX_SHIFT = 39;

	logic cclk;
	logic rst_n;
	logic start;
	fpa_op_t op;
	word_t w;
	zp_sel_t zp_sel;
	word_t zp;
	logic busy;
	logic done;

	integer seed;

	// reference model
	mant_t m_t;
	mant_t m_c;
	logic m_z;
	logic m_n;
	logic m_v;
	logic m_cf;
	shcnt_t m_cnt;

	fpa_top #(
		.MANT_W(MANT_W)
	) fpa_top_inst (
		.cclk(cclk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.w(w),
		.zp_sel(zp_sel),
		.zp(zp),
		.busy(busy),
		.done(done)
	);

	initial begin
		cclk = 1'b0;
		forever #10 cclk = ~cclk;
	end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// also ends any start pulse still on the port
	task automatic wait_done(output int cycles);
		cycles = 0;
		do begin
			@(negedge cclk);
			start = 1'b0;
			cycles++;
		end while (!done && cycles < DONE_TIMEOUT);
		if (!done) begin
			$display("done never came within %0d cycles", DONE_TIMEOUT);
			$display("Test FAILED");
			$fatal(1, "timeout waiting for done");
		end
	endtask

	task automatic check_zp(input zp_sel_t sel, input word_t exp, input string name);
		@(negedge cclk);
		zp_sel = sel;
		#2;
		check_val(name, 64'(zp), 64'(exp));
	endtask

	task automatic check_state();
		check_zp(ZP_T0, m_t[0:15], "zp_t0");
		check_zp(ZP_T1, m_t[16:31], "zp_t1");
		check_zp(ZP_T2, {m_t[32:39], 8'h00}, "zp_t2");
		check_zp(ZP_FLAGS, {m_z, m_n, m_v, m_cf, 6'b000000, m_cnt}, "zp_flags");
	endtask

	// ZP word the model expects for one selection
	function automatic word_t model_word(input zp_sel_t sel);
		case (sel)
			ZP_T1: return m_t[16:31];
			ZP_T2: return {m_t[32:39], 8'h00};
			ZP_FLAGS: return {m_z, m_n, m_v, m_cf, 6'b000000, m_cnt};
			default: return m_t[0:15];
		endcase
	endfunction

	task automatic model_apply(input fpa_op_t code, input word_t data);
		logic [40:0] wide;
		mant_t res;
		case (code)
			OP_LD0: m_t[0:15] = data;
			OP_LD1: m_t[16:31] = data;
			OP_LD2: m_t[32:39] = data[0:7];
			OP_TC: m_c = m_t;
			OP_ADD, OP_SUB: begin
				// subtract as T plus inverted C plus one
				if (code == OP_SUB)
					wide = {1'b0, m_t} + {1'b0, ~m_c} + 41'd1;
				else
					wide = {1'b0, m_t} + {1'b0, m_c};
				res = wide[39:0];
				m_z = (res == '0);
				m_n = res[0];
				if (code == OP_SUB)
					m_v = (m_t[0] != m_c[0]) && (res[0] != m_t[0]);
				else
					m_v = (m_t[0] == m_c[0]) && (res[0] != m_t[0]);
				m_cf = wide[40];
				m_t = res;
			end
			OP_SHL: begin
				if (data[0]) begin
					m_cnt = '0;
					while (m_t[0] == m_t[1] && m_t != '0 && m_cnt < shcnt_t'(MAX_SHIFT)) begin
						m_t = m_t << 1;
						m_cnt = m_cnt + shcnt_t'(1);
					end
				end else begin
					m_t = m_t << 1;
				end
			end
			OP_SHR: m_t = mant_t'($signed(m_t) >>> 1);
			default: ;
		endcase
	endtask

	task automatic run_op(input fpa_op_t code, input word_t data);
		int cycles;
		int r;
		zp_sel_t sel;
		word_t seg_before;
		// watch the segment the op writes
		case (code)
			OP_LD1: sel = ZP_T1;
			OP_LD2: sel = ZP_T2;
			default: sel = ZP_T0;
		endcase
		seg_before = model_word(sel);
		@(negedge cclk);
		start = 1'b1;
		op = code;
		w = data;
		zp_sel = sel;
		// first busy cycle, T still holds its old value
		@(negedge cclk);
		start = 1'b0;
		check_val("busy", 64'(busy), 64'd1);
		check_val("done", 64'(done), 64'd0);
		check_val("zp", 64'(zp), 64'(seg_before));
		// a stray start while busy, w kept stable
		r = $random(seed);
		if (r[4]) begin
			start = 1'b1;
			op = fpa_op_t'(r[2:0]);
		end
		wait_done(cycles);
		check_val("busy", 64'(busy), 64'd0);
		if (!(code == OP_SHL && data[0]))
			check_val("done_latency", 64'(cycles), 64'd1);
		model_apply(code, data);
		// new value already in T during the done cycle
		check_val("zp", 64'(zp), 64'(model_word(sel)));
		@(negedge cclk);
		check_val("done", 64'(done), 64'd0);
		check_state();
	endtask

	task automatic random_op();
		int r;
		word_t data;
		r = $random(seed);
		data = r[31:16];
		case (r[3:0])
			4'd0, 4'd1: run_op(OP_LD0, data);
			4'd2, 4'd3: run_op(OP_LD1, data);
			4'd4, 4'd5: run_op(OP_LD2, data);
			4'd6, 4'd7: run_op(OP_TC, data);
			4'd8, 4'd9: run_op(OP_ADD, data);
			4'd10, 4'd11: run_op(OP_SUB, data);
			4'd12: begin
				data[0] = 1'b0;
				run_op(OP_SHL, data);
			end
			4'd13: run_op(OP_SHR, data);
			default: begin
				// normalize
				data[0] = 1'b1;
				run_op(OP_SHL, data);
			end
		endcase
	endtask

	initial begin
		seed = 32'h68c2e810;
		rst_n = 1'b0;
		start = 1'b0;
		op = OP_LD0;
		w = '0;
		zp_sel = ZP_T0;
		m_t = '0;
		m_c = '0;
		m_z = 1'b0;
		m_n = 1'b0;
		m_v = 1'b0;
		m_cf = 1'b0;
		m_cnt = '0;
		repeat (4) @(posedge cclk);
		@(negedge cclk);
		rst_n = 1'b1;

		check_val("busy", 64'(busy), 64'd0);
		check_val("done", 64'(done), 64'd0);
		check_state();

		// one load per segment, LD2 keeps only the upper byte of w
		run_op(OP_LD0, 16'h8421);
		run_op(OP_LD1, 16'h1234);
		run_op(OP_LD2, 16'hbeef);

		// all zero T stops at once
		run_op(OP_LD0, 16'h0000);
		run_op(OP_LD1, 16'h0000);
		run_op(OP_LD2, 16'h0000);
		run_op(OP_SHL, 16'h8000);

		// only bit 39 set
		run_op(OP_LD2, 16'h0100);
		run_op(OP_SHL, 16'h8000);

		// all ones hits the shift limit
		run_op(OP_LD0, 16'hffff);
		run_op(OP_LD1, 16'hffff);
		run_op(OP_LD2, 16'hff00);
		run_op(OP_SHL, 16'h8000);

		for (int i = 0; i < N_OPS; i++) begin
			random_op();
		end

		$display("Test OK");
		$finish;
	end

endmodule

/* vlog.f */
common/fpa_types_pkg.sv
common/fpa_ctl_pkg.sv
fpa/alu181.sv
fpa/carry182.sv
fpa/fpa.sv
source/fpa_seq.sv
source/fpa_top.sv
testbench/fpa_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench and the fpa core with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module fpa_tb \
	-Mdir obj_dir \
	-o fpa_sim \
	-f vlog.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/fpa_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
